//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail on a reported failure"
	@echo "  clean  remove the build directory and the log"

obj_dir/Vtb_order_book: list.f $(wildcard src/*.sv bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_order_book -f list.f

test: obj_dir/Vtb_order_book
	./obj_dir/Vtb_order_book +verilator+error+limit+100 > sim.log 2>&1; \
	status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Something failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- bench/order_book_properties.sv
// ****************************
// bound into order_book_ctrl; reads its state register
// ****************************
`timescale 1ns/1ps
`default_nettype none

module order_book_properties (
    input logic                        i_clk,
    input logic                        i_reset_n,
    input logic                        i_trading_logic_ready,
    input logic                        i_data_valid,
    input logic                        i_book_is_busy,
    input order_book_pkg::ctrl_state_e i_state
);

    // read by the testbench summary
    int assert_failures = 0;

    // an accepted order runs on to FINISH before the book goes idle again
    busy_until_valid: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (i_state != order_book_pkg::IDLE) && !i_data_valid |=> i_book_is_busy)
    else begin
        $error("o_book_is_busy dropped before o_data_valid was raised");
        assert_failures++;
    end

    valid_held_until_ready: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_data_valid && !i_trading_logic_ready |=> i_data_valid)
    else begin
        $error("o_data_valid dropped before i_trading_logic_ready");
        assert_failures++;
    end

    quiet_after_reset: assert property (@(posedge i_clk)
        !i_reset_n |=> !i_data_valid && !i_book_is_busy)
    else begin
        $error("o_data_valid or o_book_is_busy high in the cycle after reset");
        assert_failures++;
    end

endmodule

`default_nettype wire

//--- bench/tb_order_book.sv
// ****************************
// default parameters only; stock ids are drawn modulo NUM_STOCKS
// ****************************
`timescale 1ns/1ps
`default_nettype none

module tb_order_book;

    localparam int NUM_STOCKS = 4;
    localparam int BOOK_DEPTH = 8;
    localparam int STOCK_W = $clog2(NUM_STOCKS);
    localparam int PRICE_W = order_book_pkg::PRICE_W;
    localparam int QTY_W = order_book_pkg::QTY_W;
    localparam int ID_W = order_book_pkg::ID_W;
    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 5;
    localparam int ADD_ORDERS = 32;
    localparam int MIXED_ORDERS = 80;
    // six targeted orders plus the fill-up and drain of one side
    localparam int TOTAL_ORDERS = ADD_ORDERS + 6 + 2 * BOOK_DEPTH + 2 + MIXED_ORDERS;
    localparam int ORDER_CYCLES = 2 * BOOK_DEPTH + 8;
    localparam int WATCHDOG_CYCLES = TOTAL_ORDERS * ORDER_CYCLES + RESET_CYCLES + 200;

    logic               i_clk;
    logic               i_reset_n;
    logic               i_data_valid;
    logic [1:0]         i_order_type;
    logic               i_trade_type;
    logic [STOCK_W-1:0] i_stock_id;
    logic [QTY_W-1:0]   i_quantity;
    logic [PRICE_W-1:0] i_price;
    logic [ID_W-1:0]    i_order_id;
    logic               i_trading_logic_ready;
    logic [PRICE_W-1:0] o_best_bid;
    logic [PRICE_W-1:0] o_best_ask;
    logic               o_book_is_busy;
    logic               o_data_valid;

    // reference book, side 1 = bids, side 0 = asks, arrival order
    logic [PRICE_W-1:0] model_price [2][NUM_STOCKS][BOOK_DEPTH];
    logic [QTY_W-1:0]   model_qty   [2][NUM_STOCKS][BOOK_DEPTH];
    logic [ID_W-1:0]    model_id    [2][NUM_STOCKS][BOOK_DEPTH];
    int                 model_count [2][NUM_STOCKS];

    logic [31:0]        lfsr_state;
    int checks;
    int value_errors;
    int other_errors;
    int assert_failures;

    order_book_top DUT (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_data_valid(i_data_valid),
        .i_order_type(i_order_type), .i_trade_type(i_trade_type), .i_stock_id(i_stock_id),
        .i_quantity(i_quantity), .i_price(i_price), .i_order_id(i_order_id),
        .i_trading_logic_ready(i_trading_logic_ready),
        .o_best_bid(o_best_bid), .o_best_ask(o_best_ask),
        .o_book_is_busy(o_book_is_busy), .o_data_valid(o_data_valid)
    );

    bind order_book_ctrl order_book_properties u_props (
        .i_clk(i_clk), .i_reset_n(i_reset_n),
        .i_trading_logic_ready(i_trading_logic_ready),
        .i_data_valid(o_data_valid), .i_book_is_busy(o_book_is_busy), .i_state(state)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic int model_find(input int side, input int stock, input logic [ID_W-1:0] id);
        for (int j = 0; j < model_count[side][stock]; j++) begin
            if (model_id[side][stock][j] == id) begin
                return j;
            end
        end
        return -1;
    endfunction

    task automatic model_remove(input int side, input int stock, input int slot);
        for (int j = slot; j < model_count[side][stock] - 1; j++) begin
            model_price[side][stock][j] = model_price[side][stock][j+1];
            model_qty[side][stock][j] = model_qty[side][stock][j+1];
            model_id[side][stock][j] = model_id[side][stock][j+1];
        end
        model_count[side][stock] = model_count[side][stock] - 1;
    endtask

    task automatic model_apply(input logic [1:0] kind, input int side, input int stock,
                               input logic [QTY_W-1:0] qty, input logic [PRICE_W-1:0] price,
                               input logic [ID_W-1:0] id);
        int slot;
        if (kind == order_book_pkg::ORDER_ADD) begin
            // a full side drops the add
            if (model_count[side][stock] < BOOK_DEPTH) begin
                slot = model_count[side][stock];
                model_price[side][stock][slot] = price;
                model_qty[side][stock][slot] = qty;
                model_id[side][stock][slot] = id;
                model_count[side][stock] = slot + 1;
            end
        end else begin
            slot = model_find(side, stock, id);
            if (slot >= 0) begin
                if (kind == order_book_pkg::ORDER_EXECUTE &&
                    qty < model_qty[side][stock][slot]) begin
                    model_qty[side][stock][slot] = model_qty[side][stock][slot] - qty;
                end else begin
                    model_remove(side, stock, slot);
                end
            end
        end
    endtask

    function automatic logic [PRICE_W-1:0] model_best_bid(input int stock);
        logic [PRICE_W-1:0] best;
        best = '0;
        for (int j = 0; j < model_count[1][stock]; j++) begin
            if (model_price[1][stock][j] > best) begin
                best = model_price[1][stock][j];
            end
        end
        return best;
    endfunction

    function automatic logic [PRICE_W-1:0] model_best_ask(input int stock);
        logic [PRICE_W-1:0] best;
        best = order_book_pkg::ASK_EMPTY;
        for (int j = 0; j < model_count[0][stock]; j++) begin
            if (model_price[0][stock][j] < best) begin
                best = model_price[0][stock][j];
            end
        end
        return best;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            value_errors++;
            $display("** Error: %s expected %h, got %h", name, expected, actual);
        end
    endtask

    // random fields that the book must not take while it is busy
    task automatic drive_junk();
        i_order_type <= 2'(rand_bits(2));
        i_trade_type <= 1'(rand_bits(1));
        i_stock_id <= STOCK_W'(rand_bits(STOCK_W));
        i_quantity <= QTY_W'(rand_bits(QTY_W));
        i_price <= rand_bits(32);
        i_order_id <= 32'h1000 + rand_bits(4);
    endtask

    task automatic send_order(input logic [1:0] kind, input int side, input int stock,
                              input logic [QTY_W-1:0] qty, input logic [PRICE_W-1:0] price,
                              input logic [ID_W-1:0] id);
        int waited;
        int hold;
        logic [PRICE_W-1:0] exp_bid;
        logic [PRICE_W-1:0] exp_ask;
        waited = 0;
        @(negedge i_clk);
        while (o_book_is_busy && waited < ORDER_CYCLES) begin
            @(negedge i_clk);
            waited++;
        end
        if (o_book_is_busy) begin
            other_errors++;
            $display("book still busy %0d cycles after the previous hand-off", waited);
        end
        @(posedge i_clk);
        i_data_valid <= 1'b1;
        i_order_type <= kind;
        i_trade_type <= 1'(side);
        i_stock_id <= STOCK_W'(stock);
        i_quantity <= qty;
        i_price <= price;
        i_order_id <= id;
        @(posedge i_clk);
        i_data_valid <= 1'b0;
        drive_junk();
        model_apply(kind, side, stock, qty, price, id);
        exp_bid = model_best_bid(stock);
        exp_ask = model_best_ask(stock);
        waited = 0;
        @(negedge i_clk);
        while (!o_data_valid && waited < ORDER_CYCLES) begin
            @(negedge i_clk);
            waited++;
        end
        if (!o_data_valid) begin
            other_errors++;
            $display("no o_data_valid within %0d cycles of an accepted order", ORDER_CYCLES);
        end
        check_value("o_best_bid", exp_bid, o_best_bid);
        check_value("o_best_ask", exp_ask, o_best_ask);
        hold = int'(rand_bits(2));
        repeat (hold) begin
            @(posedge i_clk);
            i_data_valid <= 1'b1;
            drive_junk();
            @(negedge i_clk);
            check_value("o_data_valid", 32'd1, 32'(o_data_valid));
            check_value("o_best_bid", exp_bid, o_best_bid);
            check_value("o_best_ask", exp_ask, o_best_ask);
        end
        @(posedge i_clk);
        i_data_valid <= 1'b0;
        i_trading_logic_ready <= 1'b1;
        @(posedge i_clk);
        i_trading_logic_ready <= 1'b0;
    endtask

    task automatic random_order(input logic [1:0] kind);
        int side;
        int stock;
        side = int'(rand_bits(1));
        stock = int'(rand_bits(STOCK_W)) % NUM_STOCKS;
        // small id pool so cancels and executes often hit
        send_order(kind, side, stock, QTY_W'(2 + rand_bits(6)), 32'(100 + rand_bits(8)),
                   32'h1000 + rand_bits(4));
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

    initial begin
        logic [1:0] kind;
        lfsr_state = 32'h54f67ad6;
        checks = 0;
        value_errors = 0;
        other_errors = 0;
        i_clk = 1'b0;
        i_reset_n = 1'b0;
        i_data_valid = 1'b0;
        i_order_type = 2'd0;
        i_trade_type = 1'b0;
        i_stock_id = '0;
        i_quantity = '0;
        i_price = '0;
        i_order_id = '0;
        i_trading_logic_ready = 1'b0;
        for (int s = 0; s < 2; s++) begin
            for (int k = 0; k < NUM_STOCKS; k++) begin
                model_count[s][k] = 0;
            end
        end
        repeat (RESET_CYCLES) @(posedge i_clk);
        i_reset_n <= 1'b1;
        @(negedge i_clk);
        check_value("o_best_bid", '0, o_best_bid);
        check_value("o_best_ask", order_book_pkg::ASK_EMPTY, o_best_ask);
        check_value("o_book_is_busy", 32'd0, 32'(o_book_is_busy));
        check_value("o_data_valid", 32'd0, 32'(o_data_valid));

        repeat (ADD_ORDERS) random_order(order_book_pkg::ORDER_ADD);

        send_order(order_book_pkg::ORDER_ADD, 1, 1, 16'd10, 32'd150, 32'h3000);
        send_order(order_book_pkg::ORDER_CANCEL, 1, 1, 16'd0, 32'd0, model_id[1][1][0]);
        send_order(order_book_pkg::ORDER_CANCEL, 0, 2, 16'd0, 32'd0, 32'hdead_beef);

        // 90 undercuts every random ask, so the executes work on the best ask
        send_order(order_book_pkg::ORDER_ADD, 0, 2, 16'd40, 32'd90, 32'h3001);
        send_order(order_book_pkg::ORDER_EXECUTE, 0, 2, 16'd39, 32'd0, 32'h3001);
        send_order(order_book_pkg::ORDER_EXECUTE, 0, 2, 16'd1, 32'd0, 32'h3001);

        // extras carry the highest bids, so taking one would show up
        for (int n = 0; n < BOOK_DEPTH + 2; n++) begin
            send_order(order_book_pkg::ORDER_ADD, 1, NUM_STOCKS - 1, 16'd20, 32'(400 + n * 3),
                       32'h4000 + n);
        end
        for (int n = 0; n < BOOK_DEPTH; n++) begin
            send_order(order_book_pkg::ORDER_CANCEL, 1, NUM_STOCKS - 1, 16'd0, 32'd0,
                       32'h4000 + 2 * n);
        end

        repeat (MIXED_ORDERS) begin
            kind = 2'(rand_bits(2));
            if (kind == 2'd3) begin
                kind = order_book_pkg::ORDER_ADD;
            end
            random_order(kind);
        end

        @(negedge i_clk);
        check_value("o_book_is_busy", 32'd0, 32'(o_book_is_busy));
        assert_failures = DUT.u_ctrl.u_props.assert_failures;
        $display("checks %0d, value errors %0d, other errors %0d, assertion failures %0d",
                 checks, value_errors, other_errors, assert_failures);
        if (value_errors == 0 && other_errors == 0 && assert_failures == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
src/order_book_pkg.sv
src/order_book_ctrl.sv
src/slot_counter.sv
src/order_store.sv
src/best_price_tracker.sv
src/order_book_top.sv
bench/order_book_properties.sv
bench/tb_order_book.sv

//--- src/best_price_tracker.sv
// ****************************
// outputs change only on i_done
// ****************************
`timescale 1ns/1ps
`default_nettype none

module best_price_tracker (
    input  logic                               i_clk,
    input  logic                               i_reset_n,
    input  logic                               i_clear,
    input  logic                               i_step,
    input  logic                               i_done,
    input  logic [order_book_pkg::PRICE_W-1:0] i_bid_price,
    input  logic                               i_bid_live,
    input  logic [order_book_pkg::PRICE_W-1:0] i_ask_price,
    input  logic                               i_ask_live,
    output logic [order_book_pkg::PRICE_W-1:0] o_best_bid,
    output logic [order_book_pkg::PRICE_W-1:0] o_best_ask
);

    logic [order_book_pkg::PRICE_W-1:0] run_max;
    logic [order_book_pkg::PRICE_W-1:0] run_min;
    logic [order_book_pkg::PRICE_W-1:0] next_max;
    logic [order_book_pkg::PRICE_W-1:0] next_min;

    // fold in the current slot so the last one counts on i_done
    always_comb begin
        next_max = run_max;
        next_min = run_min;
        if (i_bid_live && (i_bid_price > run_max)) begin
            next_max = i_bid_price;
        end
        if (i_ask_live && (i_ask_price < run_min)) begin
            next_min = i_ask_price;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            run_max <= '0;
            run_min <= order_book_pkg::ASK_EMPTY;
            o_best_bid <= '0;
            o_best_ask <= order_book_pkg::ASK_EMPTY;
        end else begin
            if (i_clear) begin
                run_max <= '0;
                run_min <= order_book_pkg::ASK_EMPTY;
            end else if (i_step) begin
                run_max <= next_max;
                run_min <= next_min;
            end
            if (i_done) begin
                o_best_bid <= next_max;
                o_best_ask <= next_min;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/order_book_ctrl.sv
// ****************************
// one order at a time; a new order is taken only in IDLE
// ****************************
`timescale 1ns/1ps
`default_nettype none

module order_book_ctrl #(
    parameter int NUM_STOCKS = 4
) (
    input  logic                               i_clk,
    input  logic                               i_reset_n,
    input  logic                               i_data_valid,
    input  logic [1:0]                         i_order_type,
    input  logic                               i_trade_type,
    input  logic [$clog2(NUM_STOCKS)-1:0]      i_stock_id,
    input  logic [order_book_pkg::QTY_W-1:0]   i_quantity,
    input  logic [order_book_pkg::PRICE_W-1:0] i_price,
    input  logic [order_book_pkg::ID_W-1:0]    i_order_id,
    input  logic                               i_trading_logic_ready,
    input  logic                               i_hit,
    input  logic                               i_last,
    output logic                               o_side,
    output logic [$clog2(NUM_STOCKS)-1:0]      o_stock,
    output logic [order_book_pkg::QTY_W-1:0]   o_quantity,
    output logic [order_book_pkg::PRICE_W-1:0] o_price,
    output logic [order_book_pkg::ID_W-1:0]    o_order_id,
    output logic                               o_append,
    output logic                               o_execute,
    output logic                               o_remove,
    output logic                               o_count_clear,
    output logic                               o_count_step,
    output logic                               o_book_is_busy,
    output logic                               o_data_valid
);

    order_book_pkg::ctrl_state_e state;
    order_book_pkg::ctrl_state_e next_state;
    order_book_pkg::order_type_e cmd_type;
    logic accept;

    assign accept = i_data_valid && (state == order_book_pkg::IDLE) &&
                    (i_order_type != 2'd3);

    // command held for the whole walk so the inputs may move meanwhile
    always_ff @(posedge i_clk) begin
        if (accept) begin
            cmd_type <= order_book_pkg::order_type_e'(i_order_type);
            o_side <= i_trade_type;
            o_stock <= i_stock_id;
            o_quantity <= i_quantity;
            o_price <= i_price;
            o_order_id <= i_order_id;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state <= order_book_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        o_append = 1'b0;
        o_execute = 1'b0;
        o_remove = 1'b0;
        o_count_clear = 1'b0;
        o_count_step = 1'b0;
        case (state)
            order_book_pkg::IDLE: begin
                if (accept) begin
                    o_count_clear = 1'b1;
                    if (i_order_type == order_book_pkg::ORDER_ADD) begin
                        next_state = order_book_pkg::APPEND;
                    end else begin
                        next_state = order_book_pkg::SEARCH;
                    end
                end
            end
            order_book_pkg::APPEND: begin
                o_append = 1'b1;
                o_count_clear = 1'b1;
                next_state = order_book_pkg::SCAN;
            end
            order_book_pkg::SEARCH: begin
                // hold the index on a hit so REMOVE works on that slot
                if (i_hit) begin
                    next_state = order_book_pkg::REMOVE;
                end else if (i_last) begin
                    o_count_clear = 1'b1;
                    next_state = order_book_pkg::SCAN;
                end else begin
                    o_count_step = 1'b1;
                end
            end
            order_book_pkg::REMOVE: begin
                o_remove = (cmd_type == order_book_pkg::ORDER_CANCEL);
                o_execute = (cmd_type == order_book_pkg::ORDER_EXECUTE);
                o_count_clear = 1'b1;
                next_state = order_book_pkg::SCAN;
            end
            order_book_pkg::SCAN: begin
                o_count_step = 1'b1;
                if (i_last) begin
                    next_state = order_book_pkg::FINISH;
                end
            end
            order_book_pkg::FINISH: begin
                if (i_trading_logic_ready) begin
                    next_state = order_book_pkg::IDLE;
                end
            end
            default: begin
                next_state = order_book_pkg::IDLE;
            end
        endcase
    end

    assign o_book_is_busy = (state != order_book_pkg::IDLE);
    assign o_data_valid = (state == order_book_pkg::FINISH);

endmodule

`default_nettype wire

//--- src/order_book_pkg.sv
// ****************************
// field widths, order codes and controller states shared by the book
// ****************************
`default_nettype none

package order_book_pkg;

    localparam int PRICE_W = 32;
    localparam int QTY_W = 16;
    localparam int ID_W = 32;

    // reported for an ask side with no live entry
    localparam logic [PRICE_W-1:0] ASK_EMPTY = '1;

    // code 3 is not a valid order and is ignored
    typedef enum logic [1:0] {
        ORDER_ADD = 2'd0,
        ORDER_CANCEL = 2'd1,
        ORDER_EXECUTE = 2'd2
    } order_type_e;

    typedef enum logic [2:0] {
        IDLE,
        APPEND,
        SEARCH,
        REMOVE,
        SCAN,
        FINISH
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- src/order_book_top.sv
// ****************************
// NUM_STOCKS and BOOK_DEPTH must each be at least 2
// ****************************
`timescale 1ns/1ps
`default_nettype none

module order_book_top #(
    parameter int NUM_STOCKS = 4,
    parameter int BOOK_DEPTH = 8
) (
    input  logic                               i_clk,
    input  logic                               i_reset_n,
    input  logic                               i_data_valid,
    input  logic [1:0]                         i_order_type,
    input  logic                               i_trade_type,
    input  logic [$clog2(NUM_STOCKS)-1:0]      i_stock_id,
    input  logic [order_book_pkg::QTY_W-1:0]   i_quantity,
    input  logic [order_book_pkg::PRICE_W-1:0] i_price,
    input  logic [order_book_pkg::ID_W-1:0]    i_order_id,
    input  logic                               i_trading_logic_ready,
    output logic [order_book_pkg::PRICE_W-1:0] o_best_bid,
    output logic [order_book_pkg::PRICE_W-1:0] o_best_ask,
    output logic                               o_book_is_busy,
    output logic                               o_data_valid
);

    localparam int STOCK_W = $clog2(NUM_STOCKS);
    localparam int IDX_W = $clog2(BOOK_DEPTH);

    logic                               side;
    logic [STOCK_W-1:0]                 stock;
    logic [order_book_pkg::QTY_W-1:0]   quantity;
    logic [order_book_pkg::PRICE_W-1:0] price;
    logic [order_book_pkg::ID_W-1:0]    order_id;
    logic append;
    logic execute;
    logic remove;
    logic count_clear;
    logic count_step;
    logic [IDX_W-1:0] index;
    logic last;
    logic hit;
    logic [order_book_pkg::PRICE_W-1:0] bid_price;
    logic bid_live;
    logic [order_book_pkg::PRICE_W-1:0] ask_price;
    logic ask_live;
    logic scan_done;

    // last step of a scan, the counter only steps onto its last slot in SCAN
    assign scan_done = count_step & last;

    order_book_ctrl #(.NUM_STOCKS(NUM_STOCKS)) u_ctrl (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_data_valid(i_data_valid),
        .i_order_type(i_order_type), .i_trade_type(i_trade_type), .i_stock_id(i_stock_id),
        .i_quantity(i_quantity), .i_price(i_price), .i_order_id(i_order_id),
        .i_trading_logic_ready(i_trading_logic_ready), .i_hit(hit), .i_last(last),
        .o_side(side), .o_stock(stock), .o_quantity(quantity), .o_price(price),
        .o_order_id(order_id), .o_append(append), .o_execute(execute), .o_remove(remove),
        .o_count_clear(count_clear), .o_count_step(count_step),
        .o_book_is_busy(o_book_is_busy), .o_data_valid(o_data_valid)
    );

    slot_counter #(.DEPTH(BOOK_DEPTH)) u_counter (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_clear(count_clear), .i_step(count_step),
        .o_index(index), .o_last(last)
    );

    order_store #(.NUM_STOCKS(NUM_STOCKS), .BOOK_DEPTH(BOOK_DEPTH)) u_store (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_side(side), .i_stock(stock),
        .i_index(index), .i_append(append), .i_execute(execute), .i_remove(remove),
        .i_quantity(quantity), .i_price(price), .i_order_id(order_id),
        .o_hit(hit), .o_full(), .o_bid_price(bid_price), .o_bid_live(bid_live),
        .o_ask_price(ask_price), .o_ask_live(ask_live)
    );

    best_price_tracker u_tracker (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_clear(count_clear), .i_step(count_step),
        .i_done(scan_done), .i_bid_price(bid_price), .i_bid_live(bid_live),
        .i_ask_price(ask_price), .i_ask_live(ask_live),
        .o_best_bid(o_best_bid), .o_best_ask(o_best_ask)
    );

endmodule

`default_nettype wire

//--- src/order_store.sv
// ****************************
// stock ids must be below NUM_STOCKS; adds to a full side are dropped
// ****************************
`timescale 1ns/1ps
`default_nettype none

module order_store #(
    parameter int NUM_STOCKS = 4,
    parameter int BOOK_DEPTH = 8
) (
    input  logic                               i_clk,
    input  logic                               i_reset_n,
    input  logic                               i_side,
    input  logic [$clog2(NUM_STOCKS)-1:0]      i_stock,
    input  logic [$clog2(BOOK_DEPTH)-1:0]      i_index,
    input  logic                               i_append,
    input  logic                               i_execute,
    input  logic                               i_remove,
    input  logic [order_book_pkg::QTY_W-1:0]   i_quantity,
    input  logic [order_book_pkg::PRICE_W-1:0] i_price,
    input  logic [order_book_pkg::ID_W-1:0]    i_order_id,
    output logic                               o_hit,
    output logic                               o_full,
    output logic [order_book_pkg::PRICE_W-1:0] o_bid_price,
    output logic                               o_bid_live,
    output logic [order_book_pkg::PRICE_W-1:0] o_ask_price,
    output logic                               o_ask_live
);

    localparam int IDX_W = $clog2(BOOK_DEPTH);
    localparam int CNT_W = $clog2(BOOK_DEPTH + 1);

    // side 1 holds bids, side 0 asks; entries kept in arrival order
    logic [order_book_pkg::PRICE_W-1:0] price_mem [2][NUM_STOCKS][BOOK_DEPTH];
    logic [order_book_pkg::QTY_W-1:0]   qty_mem   [2][NUM_STOCKS][BOOK_DEPTH];
    logic [order_book_pkg::ID_W-1:0]    id_mem    [2][NUM_STOCKS][BOOK_DEPTH];
    logic [CNT_W-1:0]                   count     [2][NUM_STOCKS];

    logic [CNT_W-1:0] cur_count;
    logic [CNT_W-1:0] index_ext;
    logic [IDX_W-1:0] tail;
    logic drained;
    logic do_append;
    logic do_remove;
    logic do_reduce;

    assign cur_count = count[i_side][i_stock];
    assign index_ext = CNT_W'(i_index);
    assign tail = IDX_W'(cur_count);

    assign o_full = (cur_count == CNT_W'(BOOK_DEPTH));
    assign o_hit = (index_ext < cur_count) && (id_mem[i_side][i_stock][i_index] == i_order_id);

    assign drained = (i_quantity >= qty_mem[i_side][i_stock][i_index]);
    assign do_append = i_append && !o_full;
    assign do_remove = i_remove || (i_execute && drained);
    assign do_reduce = i_execute && !drained;

    assign o_bid_price = price_mem[1][i_stock][i_index];
    assign o_bid_live = (index_ext < count[1][i_stock]);
    assign o_ask_price = price_mem[0][i_stock][i_index];
    assign o_ask_live = (index_ext < count[0][i_stock]);

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            for (int s = 0; s < 2; s++) begin
                for (int k = 0; k < NUM_STOCKS; k++) begin
                    count[s][k] <= '0;
                end
            end
        end else if (do_append) begin
            count[i_side][i_stock] <= cur_count + 1'b1;
        end else if (do_remove) begin
            count[i_side][i_stock] <= cur_count - 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_append) begin
            price_mem[i_side][i_stock][tail] <= i_price;
            qty_mem[i_side][i_stock][tail] <= i_quantity;
            id_mem[i_side][i_stock][tail] <= i_order_id;
        end else if (do_remove) begin
            // every slot above the removed one moves down in the same edge
            for (int j = 0; j < BOOK_DEPTH - 1; j++) begin
                if (j >= int'(i_index)) begin
                    price_mem[i_side][i_stock][j] <= price_mem[i_side][i_stock][j+1];
                    qty_mem[i_side][i_stock][j] <= qty_mem[i_side][i_stock][j+1];
                    id_mem[i_side][i_stock][j] <= id_mem[i_side][i_stock][j+1];
                end
            end
        end else if (do_reduce) begin
            qty_mem[i_side][i_stock][i_index] <= qty_mem[i_side][i_stock][i_index] - i_quantity;
        end
    end

endmodule

`default_nettype wire

//--- src/slot_counter.sv
// ****************************
// wraps to zero after DEPTH-1
// ****************************
`timescale 1ns/1ps
`default_nettype none

module slot_counter #(
    parameter int DEPTH = 8
) (
    input  logic                     i_clk,
    input  logic                     i_reset_n,
    input  logic                     i_clear,
    input  logic                     i_step,
    output logic [$clog2(DEPTH)-1:0] o_index,
    output logic                     o_last
);

    localparam int IDX_W = $clog2(DEPTH);

    assign o_last = (o_index == IDX_W'(DEPTH - 1));

    // clear wins over step
    always_ff @(posedge i_clk) begin
        if (!i_reset_n || i_clear) begin
            o_index <= '0;
        end else if (i_step) begin
            o_index <= o_last ? '0 : o_index + 1'b1;
        end
    end

endmodule

`default_nettype wire
